/* common/decodePkg.sv */
// Self-contained encoding for the 40-bit steered instruction
// Opcode values here are local to this decoder and not a full ISA
// FP unit instructions decode to the unit number only
package decodePkg;

	// ==============================
	// Field positions and widths
	// ==============================
	localparam int RdLsb = 0;
	localparam int OpLsb = 6;
	localparam int Rs1Lsb = 10;
	localparam int Rs2Lsb = 16;
	localparam int Rs3Lsb = 22;
	localparam int Funct5Lsb = 22;
	localparam int StoreBit = 34;
	localparam int IrqBit = 39;
	localparam int InstrW = 40;
	localparam int ConstW = 64;
	localparam int RegW = 6;

	// Functional unit numbers
	localparam logic [2:0] UnitB = 3'd1;
	localparam logic [2:0] UnitI = 3'd2;
	localparam logic [2:0] UnitF = 3'd3;
	localparam logic [2:0] UnitM = 3'd4;

	// Branch unit opcodes
	localparam logic [3:0] OpBcc = 4'd0;
	localparam logic [3:0] OpBbc = 4'd1;
	localparam logic [3:0] OpBrcc = 4'd2;
	localparam logic [3:0] OpJmp = 4'd3;
	localparam logic [3:0] OpBeqi = 4'd4;
	localparam logic [3:0] OpJal = 4'd5;
	localparam logic [3:0] OpChk = 4'd6;
	localparam logic [3:0] OpChki = 4'd7;
	localparam logic [3:0] OpCall = 4'd8;
	localparam logic [3:0] OpRet = 4'd9;
	localparam logic [3:0] OpBrk = 4'd10;
	localparam logic [3:0] OpBmisc = 4'd11;

	// Functions under BMISC
	localparam logic [4:0] FnSei = 5'd1;
	localparam logic [4:0] FnWait = 5'd2;
	localparam logic [4:0] FnRti = 5'd3;
	localparam logic [4:0] FnSync = 5'd4;
	localparam logic [4:0] FnRex = 5'd5;

	// Integer opcodes, {bits 34:33, op}
	localparam logic [5:0] AOpR1 = 6'd1;
	localparam logic [5:0] AOpR3 = 6'd2;
	localparam logic [5:0] AOpMuli = 6'd3;
	localparam logic [5:0] AOpDivi = 6'd4;
	localparam logic [5:0] AOpModi = 6'd5;
	localparam logic [5:0] AOpCsr = 6'd6;

	localparam logic [4:0] FnMul = 5'd1;
	localparam logic [4:0] FnDiv = 5'd2;
	localparam logic [4:0] FnMod = 5'd3;

	// Memory opcodes, bit 5 is the store bit
	localparam logic [5:0] MOpLdb = 6'd0;
	localparam logic [5:0] MOpLdw = 6'd1;
	localparam logic [5:0] MOpLdt = 6'd2;
	localparam logic [5:0] MOpLdp = 6'd3;
	localparam logic [5:0] MOpLdo = 6'd4;
	localparam logic [5:0] MOpLdd = 6'd5;
	localparam logic [5:0] MOpLea = 6'd6;
	localparam logic [5:0] MOpPop = 6'd7;
	localparam logic [5:0] MOpMlx = 6'd8;
	localparam logic [5:0] MOpStb = 6'd32;
	localparam logic [5:0] MOpStw = 6'd33;
	localparam logic [5:0] MOpStt = 6'd34;
	localparam logic [5:0] MOpStp = 6'd35;
	localparam logic [5:0] MOpSto = 6'd36;
	localparam logic [5:0] MOpStd = 6'd37;
	localparam logic [5:0] MOpPush = 6'd38;
	localparam logic [5:0] MOpPushc = 6'd39;
	localparam logic [5:0] MOpMsx = 6'd40;

	// Indexed funct5 that means LEA under MLX
	localparam logic [4:0] NdxLea = 5'd6;

	// Access sizes
	localparam logic [2:0] SzByte = 3'd0;
	localparam logic [2:0] SzWyde = 3'd1;
	localparam logic [2:0] SzTetra = 3'd2;
	localparam logic [2:0] SzPenta = 3'd3;
	localparam logic [2:0] SzOcta = 3'd4;
	localparam logic [2:0] SzDeci = 3'd5;
	localparam logic [2:0] SzDefaultAlu = 3'd3;

	localparam logic [RegW-1:0] CallLinkReg = 6'd61;

	// ==============================
	// Instruction views
	// ==============================
	typedef struct packed {
		logic [17:0] upper;
		logic [5:0] offLo;
		logic [5:0] rs1;
		logic [3:0] op;
		logic [5:0] rd;
	} loadView_t;

	typedef struct packed {
		logic [17:0] upper;
		logic [5:0] rs2;
		logic [5:0] rs1;
		logic [3:0] op;
		logic [5:0] rsData;
	} storeView_t;

	typedef union packed {
		loadView_t loadView;
		storeView_t storeView;
	} instrWord_t;

	// Extended 6-bit opcode used by the integer and memory units
	function automatic logic [5:0] extOpcode(instrWord_t ins);
		return {ins[StoreBit -: 2], ins[OpLsb +: 4]};
	endfunction

	// ==============================
	// Per-unit results and record
	// ==============================
	typedef struct packed {
		logic br;
		logic brcc;
		logic jmp;
		logic jal;
		logic call;
		logic ret;
		logic brk;
		logic irq;
		logic rti;
		logic sei;
		logic waitOp;
		logic rex;
		logic chk;
		logic chki;
		logic sync;
		logic bt;
		logic rdValid;
		logic hasConst;
		logic canEx;
	} branchInfo_t;

	typedef struct packed {
		logic hasConst;
		logic canEx;
		logic alu0;
		logic [2:0] opSize;
	} aluInfo_t;

	typedef struct packed {
		logic load;
		logic store;
		logic push;
		logic pushc;
		logic pop;
		logic lea;
		logic ndx;
		logic mem2;
		logic [2:0] memSize;
		logic hasConst;
		logic canEx;
		logic rdValid;
		logic rd2Valid;
		logic wrRf;
	} memInfo_t;

	typedef struct packed {
		logic [2:0] unit;
		logic [ConstW-1:0] constant;
		logic [RegW-1:0] rs1;
		logic [RegW-1:0] rs2;
		logic [RegW-1:0] rs3;
		logic [RegW-1:0] rd;
		logic [RegW-1:0] rd2;
		logic hasConst;
		logic canEx;
		logic rfw;
		logic br;
		logic brcc;
		logic jmp;
		logic jal;
		logic call;
		logic ret;
		logic brk;
		logic irq;
		logic rti;
		logic sei;
		logic waitOp;
		logic rex;
		logic chk;
		logic sync;
		logic bt;
		logic alu;
		logic alu0;
		logic [2:0] opSize;
		logic load;
		logic store;
		logic preload;
		logic push;
		logic pushc;
		logic pop;
		logic lea;
		logic ndx;
		logic mem2;
		logic [2:0] memSize;
	} decodeRec_t;

endpackage

/* design/branchDecode.sv */
// Branch unit flags, all zero when the unit is not the branch unit
// Conditional branch covers Bcc, BBc, BEQI and both checks but not BRcc
module branchDecode
(
	input  logic [2:0]               unit,
	input  decodePkg::instrWord_t    instr,
	output decodePkg::branchInfo_t   bInfo
);

	logic [3:0] op;
	logic [4:0] funct;

	assign op = instr.loadView.op;
	assign funct = instr[decodePkg::Funct5Lsb +: 5];

	always_comb
	begin
		bInfo = '0;
		if (unit == decodePkg::UnitB)
		begin
			case (op)
				decodePkg::OpBcc, decodePkg::OpBbc, decodePkg::OpBeqi:
					bInfo.br = 1'b1;
				decodePkg::OpBrcc:
					bInfo.brcc = 1'b1;
				decodePkg::OpJmp:
					bInfo.jmp = 1'b1;
				decodePkg::OpJal:
				begin
					bInfo.jal = 1'b1;
					bInfo.rdValid = 1'b1;
					bInfo.hasConst = 1'b1;
					bInfo.bt = 1'b1;
				end
				decodePkg::OpChk, decodePkg::OpChki:
				begin
					bInfo.br = 1'b1;
					bInfo.chk = 1'b1;
					bInfo.canEx = 1'b1;
					// Immediate form carries its bound in the constant
					bInfo.chki = op == decodePkg::OpChki;
					bInfo.hasConst = op == decodePkg::OpChki;
				end
				decodePkg::OpCall:
					bInfo.call = 1'b1;
				decodePkg::OpRet:
				begin
					bInfo.ret = 1'b1;
					bInfo.rdValid = 1'b1;
					bInfo.bt = 1'b1;
				end
				decodePkg::OpBrk:
				begin
					bInfo.brk = 1'b1;
					bInfo.irq = instr[decodePkg::IrqBit];
					bInfo.sync = 1'b1;
					bInfo.bt = 1'b1;
					bInfo.canEx = 1'b1;
				end
				decodePkg::OpBmisc:
				begin
					bInfo.sei = funct == decodePkg::FnSei;
					bInfo.rdValid = funct == decodePkg::FnSei;
					bInfo.waitOp = funct == decodePkg::FnWait;
					bInfo.rex = funct == decodePkg::FnRex;
					bInfo.rti = funct == decodePkg::FnRti;
					// RTI also redirects the target and serializes
					bInfo.bt = funct == decodePkg::FnRti;
					bInfo.sync = funct == decodePkg::FnSync || funct == decodePkg::FnRti;
				end
				default:
					bInfo = '0;
			endcase
		end
	end

endmodule

/* design/aluDecode.sv */
// Integer unit decode, all zero when the unit is not the integer unit
// Only R3 carries an explicit operand size, the rest use the default word
module aluDecode
(
	input  logic [2:0]              unit,
	input  decodePkg::instrWord_t   instr,
	output decodePkg::aluInfo_t     aInfo
);

	logic [5:0] opc;
	logic [4:0] funct;
	logic mulDivMod;

	assign opc = decodePkg::extOpcode(instr);
	assign funct = instr[decodePkg::Funct5Lsb +: 5];
	assign mulDivMod = funct == decodePkg::FnMul || funct == decodePkg::FnDiv
		|| funct == decodePkg::FnMod;

	always_comb
	begin
		aInfo = '0;
		if (unit == decodePkg::UnitI)
		begin
			aInfo.hasConst = !(opc == decodePkg::AOpR1 || opc == decodePkg::AOpR3);
			// CSR access is only wired to ALU 0
			aInfo.alu0 = opc == decodePkg::AOpCsr;
			aInfo.opSize = decodePkg::SzDefaultAlu;
			case (opc)
				decodePkg::AOpMuli, decodePkg::AOpDivi, decodePkg::AOpModi:
					aInfo.canEx = 1'b1;
				decodePkg::AOpR3:
				begin
					aInfo.canEx = mulDivMod;
					aInfo.opSize = instr[30:28];
				end
				default:
					aInfo.canEx = 1'b0;
			endcase
		end
	end

endmodule

/* memory/memDecode.sv */
// Memory unit classification, all zero when the unit is not the memory unit
// Indexed forms take their access size from funct5, unknown values give deci
// Every memory op may fault, so canEx is always set for this unit
module memDecode
(
	input  logic [2:0]              unit,
	input  decodePkg::instrWord_t   instr,
	output decodePkg::memInfo_t     mInfo
);

	logic [5:0] opc;
	logic [4:0] funct;
	logic isMlx;
	logic isMsx;
	logic [1:0] scale;
	logic [1:0] dataLo;
	logic [2:0] ndxSize;

	assign opc = decodePkg::extOpcode(instr);
	assign funct = instr[decodePkg::Funct5Lsb +: 5];
	assign isMlx = opc == decodePkg::MOpMlx;
	assign isMsx = opc == decodePkg::MOpMsx;

	// Scale sits at bits 17:16 in both layouts
	assign scale = instr.loadView.offLo[1:0];
	assign dataLo = instr.storeView.rsData[1:0];

	// Indexed size from funct5
	always_comb
	begin
		case (funct)
			5'd0: ndxSize = decodePkg::SzByte;
			5'd1: ndxSize = decodePkg::SzWyde;
			5'd2: ndxSize = decodePkg::SzTetra;
			5'd3: ndxSize = decodePkg::SzPenta;
			5'd4: ndxSize = decodePkg::SzOcta;
			default: ndxSize = decodePkg::SzDeci;
		endcase
	end

	always_comb
	begin
		mInfo = '0;
		if (unit == decodePkg::UnitM)
		begin
			mInfo.canEx = 1'b1;
			mInfo.store = instr[decodePkg::StoreBit];
			mInfo.load = !instr[decodePkg::StoreBit] && opc != decodePkg::MOpPushc;
			mInfo.pushc = opc == decodePkg::MOpPushc;
			mInfo.push = opc == decodePkg::MOpPush || mInfo.pushc;
			mInfo.pop = opc == decodePkg::MOpPop;
			mInfo.ndx = isMlx || isMsx;
			mInfo.lea = opc == decodePkg::MOpLea || (isMlx && funct == decodePkg::NdxLea);
			mInfo.hasConst = !(mInfo.ndx || opc == decodePkg::MOpPush || mInfo.pop);
			// Nonzero scale means the index register is updated
			mInfo.rd2Valid = mInfo.pop || (mInfo.ndx && scale != 2'd0);
			mInfo.mem2 = opc == decodePkg::MOpLea || mInfo.pop || mInfo.push
				|| (mInfo.ndx && (scale == 2'd1 || scale == 2'd2));
			mInfo.rdValid = mInfo.load || mInfo.push;
			mInfo.wrRf = mInfo.load || mInfo.push || (isMsx && dataLo != 2'd0);

			case (opc)
				decodePkg::MOpLdb, decodePkg::MOpStb:
					mInfo.memSize = decodePkg::SzByte;
				decodePkg::MOpLdw, decodePkg::MOpStw:
					mInfo.memSize = decodePkg::SzWyde;
				decodePkg::MOpLdt, decodePkg::MOpStt:
					mInfo.memSize = decodePkg::SzTetra;
				decodePkg::MOpLdp, decodePkg::MOpStp:
					mInfo.memSize = decodePkg::SzPenta;
				decodePkg::MOpLdo, decodePkg::MOpSto:
					mInfo.memSize = decodePkg::SzOcta;
				decodePkg::MOpMlx, decodePkg::MOpMsx:
					mInfo.memSize = ndxSize;
				decodePkg::MOpLdd, decodePkg::MOpStd, decodePkg::MOpLea, decodePkg::MOpPop,
				decodePkg::MOpPush, decodePkg::MOpPushc:
					mInfo.memSize = decodePkg::SzDeci;
				default:
					mInfo.memSize = decodePkg::SzDeci;
			endcase
		end
	end

endmodule

/* design/constExtract.sv */
// Immediate selection by format, always sign-extended from bit 39
// Short forms skip bits 34:33, which hold the extended opcode
module constExtract
(
	input  logic [2:0]                    unit,
	input  decodePkg::instrWord_t         instr,
	input  logic                          pushc,
	input  logic                          chki,
	output logic [decodePkg::ConstW-1:0]  constant
);

	localparam int ImmW = 24;

	logic [ImmW-1:0] imm;
	logic signBit;
	logic isJal;
	logic isMemStore;

	assign signBit = instr[decodePkg::InstrW-1];
	assign isJal = unit == decodePkg::UnitB && instr.loadView.op == decodePkg::OpJal;
	assign isMemStore = unit == decodePkg::UnitM && instr[decodePkg::StoreBit];

	always_comb
	begin
		if (pushc || isJal)
			// Bits 39:16
			imm = {instr.loadView.upper, instr.loadView.offLo};
		else if (chki)
			// Bits 39:22 then 5:0
			imm = {instr.storeView.upper, instr.storeView.rsData};
		else if (isMemStore)
			imm = {{2{signBit}}, instr.storeView.upper[17:13], instr.storeView.upper[10:0],
				instr.storeView.rsData};
		else
			imm = {{2{signBit}}, instr.loadView.upper[17:13], instr.loadView.upper[10:0],
				instr.loadView.offLo};
	end

	assign constant = {{(decodePkg::ConstW-ImmW){imm[ImmW-1]}}, imm};

endmodule

/* design/decodeRegister.sv */
// Merges per-unit results and registers the decode record
// The record only updates on a valid instruction, otherwise it holds
// rfw is suppressed when both rename targets are zero
module decodeRegister
(
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          instrValid,
	input  logic [2:0]                    unit,
	input  decodePkg::instrWord_t         instr,
	input  logic [5:0]                    rt,
	input  logic [5:0]                    rd2Target,
	input  decodePkg::branchInfo_t        bInfo,
	input  decodePkg::aluInfo_t           aInfo,
	input  decodePkg::memInfo_t           mInfo,
	input  logic [decodePkg::ConstW-1:0]  constant,
	output logic                          decValid,
	output decodePkg::decodeRec_t         dec
);

	decodePkg::decodeRec_t nextRec;
	logic knownUnit;
	logic noTarget;
	logic unitWrites;
	logic [decodePkg::RegW-1:0] rdField;
	logic [decodePkg::RegW-1:0] rs1Field;

	assign noTarget = rt == 6'd0 && rd2Target == 6'd0;
	assign rdField = instr[decodePkg::RdLsb +: decodePkg::RegW];
	assign rs1Field = instr[decodePkg::Rs1Lsb +: decodePkg::RegW];

	// FP unit and unknown units carry the unit number only
	always_comb
	begin
		case (unit)
			decodePkg::UnitB, decodePkg::UnitI, decodePkg::UnitM:
				knownUnit = 1'b1;
			decodePkg::UnitF:
				knownUnit = 1'b0;
			default:
				knownUnit = 1'b0;
		endcase
	end

	// Register file write rule per unit
	always_comb
	begin
		case (unit)
			decodePkg::UnitB: unitWrites = bInfo.jal || bInfo.call || bInfo.ret || bInfo.sei;
			decodePkg::UnitI: unitWrites = 1'b1;
			decodePkg::UnitM: unitWrites = mInfo.wrRf;
			default: unitWrites = 1'b0;
		endcase
	end

	// ==============================
	// Record assembly
	// ==============================
	always_comb
	begin
		nextRec = '0;
		nextRec.unit = unit;
		if (knownUnit)
		begin
			nextRec.constant = constant;
			nextRec.rs1 = rs1Field;
			nextRec.rs2 = instr[decodePkg::Rs2Lsb +: decodePkg::RegW];
			nextRec.rs3 = instr[decodePkg::Rs3Lsb +: decodePkg::RegW];
			if (bInfo.call)
				nextRec.rd = decodePkg::CallLinkReg;
			else if (bInfo.rdValid || unit == decodePkg::UnitI || mInfo.rdValid)
				nextRec.rd = rdField;
			nextRec.rd2 = mInfo.rd2Valid ? rs1Field : '0;
			nextRec.hasConst = bInfo.hasConst || aInfo.hasConst || mInfo.hasConst;
			nextRec.canEx = bInfo.canEx || aInfo.canEx || mInfo.canEx;
			nextRec.rfw = unitWrites && !noTarget;

			nextRec.br = bInfo.br;
			nextRec.brcc = bInfo.brcc;
			nextRec.jmp = bInfo.jmp;
			nextRec.jal = bInfo.jal;
			nextRec.call = bInfo.call;
			nextRec.ret = bInfo.ret;
			nextRec.brk = bInfo.brk;
			nextRec.irq = bInfo.irq;
			nextRec.rti = bInfo.rti;
			nextRec.sei = bInfo.sei;
			nextRec.waitOp = bInfo.waitOp;
			nextRec.rex = bInfo.rex;
			nextRec.chk = bInfo.chk;
			nextRec.sync = bInfo.sync;
			nextRec.bt = bInfo.bt;

			nextRec.alu = unit == decodePkg::UnitI;
			nextRec.alu0 = aInfo.alu0;
			nextRec.opSize = aInfo.opSize;

			nextRec.load = mInfo.load;
			nextRec.store = mInfo.store;
			// Load with nothing to rename only warms the cache
			nextRec.preload = mInfo.load && noTarget;
			nextRec.push = mInfo.push;
			nextRec.pushc = mInfo.pushc;
			nextRec.pop = mInfo.pop;
			nextRec.lea = mInfo.lea;
			nextRec.ndx = mInfo.ndx;
			nextRec.mem2 = mInfo.mem2;
			nextRec.memSize = mInfo.memSize;
		end
	end

	// ==============================
	// Decode register
	// ==============================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			decValid <= 1'b0;
			dec <= '0;
		end
		else
		begin
			decValid <= instrValid;
			if (instrValid)
				dec <= nextRec;
		end
	end

endmodule

/* design/instrDecoder.sv */
// Decode stage top, one record per valid instruction, one cycle later
// No back-pressure, instructions arrive already steered to a unit
module instrDecoder
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic [2:0]              unit,
	input  decodePkg::instrWord_t   instr,
	input  logic                    instrValid,
	input  logic [5:0]              rt,
	input  logic [5:0]              rd2Target,
	output logic                    decValid,
	output decodePkg::decodeRec_t   dec
);

	decodePkg::branchInfo_t bInfo;
	decodePkg::aluInfo_t aInfo;
	decodePkg::memInfo_t mInfo;
	logic [decodePkg::ConstW-1:0] constant;

	// Per-unit combinational decoders
	branchDecode branchDecode_i (
		.unit(unit),
		.instr(instr),
		.bInfo(bInfo)
	);

	aluDecode aluDecode_i (
		.unit(unit),
		.instr(instr),
		.aInfo(aInfo)
	);

	memDecode memDecode_i (
		.unit(unit),
		.instr(instr),
		.mInfo(mInfo)
	);

	constExtract constExtract_i (
		.unit(unit),
		.instr(instr),
		.pushc(mInfo.pushc),
		.chki(bInfo.chki),
		.constant(constant)
	);

	decodeRegister decodeRegister_i (
		.clk(clk),
		.rst(rst),
		.instrValid(instrValid),
		.unit(unit),
		.instr(instr),
		.rt(rt),
		.rd2Target(rd2Target),
		.bInfo(bInfo),
		.aInfo(aInfo),
		.mInfo(mInfo),
		.constant(constant),
		.decValid(decValid),
		.dec(dec)
	);

endmodule

/* tests/instrDecoderTb.sv */
// Random decode stimulus checked against restated decode rules
// Expected record is queued one cycle ahead of the DUT output
// The record holds its last value while instrValid is low
module instrDecoderTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ClkPeriod = 8;
	localparam int NumVectors = 4000;
	localparam logic [5:0] MemOps [18] = '{
		decodePkg::MOpLdb, decodePkg::MOpLdw, decodePkg::MOpLdt, decodePkg::MOpLdp,
		decodePkg::MOpLdo, decodePkg::MOpLdd, decodePkg::MOpLea, decodePkg::MOpPop,
		decodePkg::MOpMlx, decodePkg::MOpStb, decodePkg::MOpStw, decodePkg::MOpStt,
		decodePkg::MOpStp, decodePkg::MOpSto, decodePkg::MOpStd, decodePkg::MOpPush,
		decodePkg::MOpPushc, decodePkg::MOpMsx
	};

	typedef struct packed {
		logic valid;
		decodePkg::decodeRec_t rec;
	} expect_t;

	logic clk;
	logic rst;
	logic [2:0] unit;
	decodePkg::instrWord_t instr;
	logic instrValid;
	logic [5:0] rt;
	logic [5:0] rd2Target;
	logic decValid;
	decodePkg::decodeRec_t dec;

	integer seed;
	int errCount;
	int vecCount;
	logic checkEn;
	logic expValid;
	decodePkg::decodeRec_t expRec;
	expect_t pending[$];

	logic [17:0] gotRegs;
	logic [17:0] expRegs;
	logic [14:0] gotBranch;
	logic [14:0] expBranch;
	logic [4:0] gotAlu;
	logic [4:0] expAlu;
	logic [10:0] gotMem;
	logic [10:0] expMem;

	instrDecoder instrDecoder_i (
		.clk(clk),
		.rst(rst),
		.unit(unit),
		.instr(instr),
		.instrValid(instrValid),
		.rt(rt),
		.rd2Target(rd2Target),
		.decValid(decValid),
		.dec(dec)
	);

	initial
	begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	// Field groups for the flag checks
	assign gotRegs = {dec.rs1, dec.rs2, dec.rs3};
	assign expRegs = {expRec.rs1, expRec.rs2, expRec.rs3};
	assign gotBranch = {dec.br, dec.brcc, dec.jmp, dec.jal, dec.call, dec.ret, dec.brk, dec.irq,
		dec.rti, dec.sei, dec.waitOp, dec.rex, dec.chk, dec.sync, dec.bt};
	assign expBranch = {expRec.br, expRec.brcc, expRec.jmp, expRec.jal, expRec.call, expRec.ret,
		expRec.brk, expRec.irq, expRec.rti, expRec.sei, expRec.waitOp, expRec.rex, expRec.chk,
		expRec.sync, expRec.bt};
	assign gotAlu = {dec.alu, dec.alu0, dec.opSize};
	assign expAlu = {expRec.alu, expRec.alu0, expRec.opSize};
	assign gotMem = {dec.load, dec.store, dec.push, dec.pushc, dec.pop, dec.lea, dec.ndx,
		dec.mem2, dec.memSize};
	assign expMem = {expRec.load, expRec.store, expRec.push, expRec.pushc, expRec.pop,
		expRec.lea, expRec.ndx, expRec.mem2, expRec.memSize};

	function automatic logic [31:0] pick(input logic [31:0] n);
		logic [31:0] r;
		r = $random(seed);
		return r % n;
	endfunction

	task automatic reportMismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		errCount++;
		$display("FAIL %s got %h expected %h", name, got, exp);
	endtask

	// ==============================
	// Reference decode rules
	// ==============================
	function automatic decodePkg::decodeRec_t expectRecord(input logic [2:0] u,
			input logic [39:0] w, input logic [5:0] t, input logic [5:0] t2);
		decodePkg::decodeRec_t r;
		logic [3:0] op;
		logic [5:0] opc;
		logic [4:0] fn;
		logic [1:0] scale;
		logic [23:0] imm;
		logic noTarget;
		logic rdValid;
		logic writes;
		r = '0;
		r.unit = u;
		// FP and unknown units carry the unit number only
		if (u != decodePkg::UnitB && u != decodePkg::UnitI && u != decodePkg::UnitM)
			return r;
		op = w[9:6];
		opc = {w[34:33], w[9:6]};
		fn = w[26:22];
		scale = w[17:16];
		noTarget = t == 6'd0 && t2 == 6'd0;
		rdValid = 1'b0;
		writes = 1'b0;
		r.rs1 = w[15:10];
		r.rs2 = w[21:16];
		r.rs3 = w[27:22];

		if ((u == decodePkg::UnitM && opc == decodePkg::MOpPushc)
			|| (u == decodePkg::UnitB && op == decodePkg::OpJal))
			imm = w[39:16];
		else if (u == decodePkg::UnitB && op == decodePkg::OpChki)
			imm = {w[39:22], w[5:0]};
		else if (u == decodePkg::UnitM && w[34])
			imm = {{2{w[39]}}, w[39:35], w[32:22], w[5:0]};
		else
			imm = {{2{w[39]}}, w[39:35], w[32:16]};
		r.constant = {{40{w[39]}}, imm};

		if (u == decodePkg::UnitB)
		begin
			case (op)
				decodePkg::OpBcc, decodePkg::OpBbc, decodePkg::OpBeqi:
					r.br = 1'b1;
				decodePkg::OpBrcc:
					r.brcc = 1'b1;
				decodePkg::OpJmp:
					r.jmp = 1'b1;
				decodePkg::OpJal:
				begin
					r.jal = 1'b1;
					r.hasConst = 1'b1;
					r.bt = 1'b1;
					rdValid = 1'b1;
				end
				decodePkg::OpChk, decodePkg::OpChki:
				begin
					r.br = 1'b1;
					r.chk = 1'b1;
					r.canEx = 1'b1;
					r.hasConst = op == decodePkg::OpChki;
				end
				decodePkg::OpCall:
					r.call = 1'b1;
				decodePkg::OpRet:
				begin
					r.ret = 1'b1;
					r.bt = 1'b1;
					rdValid = 1'b1;
				end
				decodePkg::OpBrk:
				begin
					r.brk = 1'b1;
					r.irq = w[39];
					r.sync = 1'b1;
					r.bt = 1'b1;
					r.canEx = 1'b1;
				end
				decodePkg::OpBmisc:
				begin
					r.sei = fn == decodePkg::FnSei;
					r.waitOp = fn == decodePkg::FnWait;
					r.rti = fn == decodePkg::FnRti;
					r.rex = fn == decodePkg::FnRex;
					r.sync = fn == decodePkg::FnSync || fn == decodePkg::FnRti;
					r.bt = r.rti;
					rdValid = r.sei;
				end
				default:
					r.br = 1'b0;
			endcase
			writes = r.jal || r.call || r.ret || r.sei;
			if (r.call)
				r.rd = decodePkg::CallLinkReg;
			else if (rdValid)
				r.rd = w[5:0];
		end
		else if (u == decodePkg::UnitI)
		begin
			r.alu = 1'b1;
			r.hasConst = opc != decodePkg::AOpR1 && opc != decodePkg::AOpR3;
			r.alu0 = opc == decodePkg::AOpCsr;
			r.opSize = (opc == decodePkg::AOpR3) ? w[30:28] : decodePkg::SzDefaultAlu;
			r.canEx = opc == decodePkg::AOpMuli || opc == decodePkg::AOpDivi
				|| opc == decodePkg::AOpModi || (opc == decodePkg::AOpR3
				&& (fn == decodePkg::FnMul || fn == decodePkg::FnDiv || fn == decodePkg::FnMod));
			r.rd = w[5:0];
			writes = 1'b1;
		end
		else
		begin
			r.canEx = 1'b1;
			r.store = w[34];
			r.load = !w[34] && opc != decodePkg::MOpPushc;
			r.pushc = opc == decodePkg::MOpPushc;
			r.push = opc == decodePkg::MOpPush || r.pushc;
			r.pop = opc == decodePkg::MOpPop;
			r.ndx = opc == decodePkg::MOpMlx || opc == decodePkg::MOpMsx;
			r.lea = opc == decodePkg::MOpLea || (opc == decodePkg::MOpMlx && fn == 5'd6);
			r.hasConst = !(r.ndx || opc == decodePkg::MOpPush || r.pop);
			r.mem2 = opc == decodePkg::MOpLea || r.pop || r.push
				|| (r.ndx && (scale == 2'd1 || scale == 2'd2));
			r.preload = r.load && noTarget;
			case (opc)
				decodePkg::MOpLdb, decodePkg::MOpStb: r.memSize = decodePkg::SzByte;
				decodePkg::MOpLdw, decodePkg::MOpStw: r.memSize = decodePkg::SzWyde;
				decodePkg::MOpLdt, decodePkg::MOpStt: r.memSize = decodePkg::SzTetra;
				decodePkg::MOpLdp, decodePkg::MOpStp: r.memSize = decodePkg::SzPenta;
				decodePkg::MOpLdo, decodePkg::MOpSto: r.memSize = decodePkg::SzOcta;
				decodePkg::MOpMlx, decodePkg::MOpMsx:
					r.memSize = (fn <= 5'd4) ? fn[2:0] : decodePkg::SzDeci;
				default: r.memSize = decodePkg::SzDeci;
			endcase
			if (r.load || r.push)
				r.rd = w[5:0];
			if (r.pop || (r.ndx && scale != 2'd0))
				r.rd2 = w[15:10];
			writes = r.load || r.push || (opc == decodePkg::MOpMsx && w[1:0] != 2'd0);
		end
		r.rfw = writes && !noTarget;
		return r;
	endfunction

	// ==============================
	// Stimulus
	// ==============================
	task automatic makeRandom(output logic v, output logic [2:0] u, output logic [39:0] w,
			output logic [5:0] t, output logic [5:0] t2);
		logic [63:0] raw;
		logic [5:0] opc;
		raw = {$random(seed), $random(seed)};
		w = raw[39:0];
		v = pick(32'd8) != 32'd0;
		case (pick(32'd10))
			0, 1, 2: u = decodePkg::UnitB;
			3, 4: u = decodePkg::UnitI;
			5, 6, 7: u = decodePkg::UnitM;
			8: u = decodePkg::UnitF;
			default: u = 3'(pick(32'd8));
		endcase
		if (u == decodePkg::UnitB)
		begin
			w[9:6] = 4'(pick(32'd12));
			if (w[9:6] == decodePkg::OpBmisc)
				w[26:22] = 5'(pick(32'd7));
		end
		else if (u == decodePkg::UnitI && pick(32'd10) < 32'd8)
		begin
			opc = 6'(pick(32'd8));
			{w[34:33], w[9:6]} = opc;
			if (opc == decodePkg::AOpR3 && pick(32'd2) == 32'd0)
				w[26:22] = 5'(pick(32'd5));
		end
		else if (u == decodePkg::UnitM)
		begin
			opc = MemOps[5'(pick(32'd18))];
			{w[34:33], w[9:6]} = opc;
			if (opc == decodePkg::MOpMlx || opc == decodePkg::MOpMsx)
				w[26:22] = 5'(pick(32'd8));
		end
		// Both rename targets zero about a quarter of the time
		if (pick(32'd4) == 32'd0)
		begin
			t = 6'd0;
			t2 = 6'd0;
		end
		else
		begin
			t = 6'(pick(32'd64));
			t2 = 6'(pick(32'd64));
		end
	endtask

	task automatic applyVector(input logic v, input logic [2:0] u, input logic [39:0] w,
			input logic [5:0] t, input logic [5:0] t2);
		expect_t e;
		@(negedge clk);
		// Retire the vector captured on the last rising edge
		if (pending.size() > 0)
		begin
			e = pending.pop_front();
			expValid = e.valid;
			if (e.valid)
				expRec = e.rec;
		end
		instrValid = v;
		unit = u;
		instr = w;
		rt = t;
		rd2Target = t2;
		e.valid = v;
		e.rec = expectRecord(u, w, t, t2);
		pending.push_back(e);
		vecCount++;
	endtask

	// ==============================
	// Checks
	// ==============================
	validCheck: assert property (@(posedge clk) !checkEn || decValid == expValid)
		else reportMismatch("decValid", 64'($sampled(decValid)), 64'($sampled(expValid)));
	unitCheck: assert property (@(posedge clk) !checkEn || dec.unit == expRec.unit)
		else reportMismatch("dec.unit", 64'($sampled(dec.unit)), 64'($sampled(expRec.unit)));
	constCheck: assert property (@(posedge clk) !checkEn || dec.constant == expRec.constant)
		else reportMismatch("dec.constant", $sampled(dec.constant), $sampled(expRec.constant));
	hasConstCheck: assert property (@(posedge clk) !checkEn || dec.hasConst == expRec.hasConst)
		else reportMismatch("dec.hasConst", 64'($sampled(dec.hasConst)),
			64'($sampled(expRec.hasConst)));
	canExCheck: assert property (@(posedge clk) !checkEn || dec.canEx == expRec.canEx)
		else reportMismatch("dec.canEx", 64'($sampled(dec.canEx)), 64'($sampled(expRec.canEx)));
	rfwCheck: assert property (@(posedge clk) !checkEn || dec.rfw == expRec.rfw)
		else reportMismatch("dec.rfw", 64'($sampled(dec.rfw)), 64'($sampled(expRec.rfw)));
	preloadCheck: assert property (@(posedge clk) !checkEn || dec.preload == expRec.preload)
		else reportMismatch("dec.preload", 64'($sampled(dec.preload)),
			64'($sampled(expRec.preload)));
	rdCheck: assert property (@(posedge clk) !checkEn || dec.rd == expRec.rd)
		else reportMismatch("dec.rd", 64'($sampled(dec.rd)), 64'($sampled(expRec.rd)));
	rd2Check: assert property (@(posedge clk) !checkEn || dec.rd2 == expRec.rd2)
		else reportMismatch("dec.rd2", 64'($sampled(dec.rd2)), 64'($sampled(expRec.rd2)));
	regsCheck: assert property (@(posedge clk) !checkEn || gotRegs == expRegs)
		else reportMismatch("dec.rs1/rs2/rs3", 64'($sampled(gotRegs)), 64'($sampled(expRegs)));
	branchCheck: assert property (@(posedge clk) !checkEn || gotBranch == expBranch)
		else reportMismatch("dec.br..bt", 64'($sampled(gotBranch)), 64'($sampled(expBranch)));
	aluCheck: assert property (@(posedge clk) !checkEn || gotAlu == expAlu)
		else reportMismatch("dec.alu/alu0/opSize", 64'($sampled(gotAlu)), 64'($sampled(expAlu)));
	memCheck: assert property (@(posedge clk) !checkEn || gotMem == expMem)
		else reportMismatch("dec.load..memSize", 64'($sampled(gotMem)), 64'($sampled(expMem)));

	// Watchdog sized from the vector count
	initial
	begin
		#((NumVectors + 16) * ClkPeriod + 200);
		$display("Watchdog expired before the vectors were all applied");
		$display("Test failed");
		$finish;
	end

	initial
	begin
		logic v;
		logic [2:0] u;
		logic [39:0] w;
		logic [5:0] t;
		logic [5:0] t2;
		seed = 38183;
		errCount = 0;
		vecCount = 0;
		checkEn = 1'b0;
		expValid = 1'b0;
		expRec = '0;
		rst = 1'b1;
		unit = 3'd0;
		instr = '0;
		instrValid = 1'b0;
		rt = 6'd0;
		rd2Target = 6'd0;

		// Reset over two rising edges, record must read zero
		@(posedge clk);
		@(negedge clk);
		checkEn = 1'b1;
		@(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		for (int i = 0; i < NumVectors; i++)
		begin
			makeRandom(v, u, w, t, t2);
			applyVector(v, u, w, t, t2);
		end
		// Flush the last vectors through the register
		applyVector(1'b0, 3'd0, 40'd0, 6'd0, 6'd0);
		applyVector(1'b0, 3'd0, 40'd0, 6'd0, 6'd0);
		@(posedge clk);
		@(negedge clk);

		$display("Vectors applied %0d, errors %0d", vecCount, errCount);
		if (errCount == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* sources.f */
common/decodePkg.sv
design/branchDecode.sv
design/aluDecode.sv
memory/memDecode.sv
design/constExtract.sv
design/decodeRegister.sv
design/instrDecoder.sv
tests/instrDecoderTb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and pass only if the pass message is printed
cd "$(dirname "$0")" \
	&& verilator --binary --assert --timescale 1ns/1ps --top-module instrDecoderTb \
		-f sources.f -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -q "Test completed successfully" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
